// File: design/rx_core_pkg.sv
/* Shared definitions for the RX core slice: settings bus addresses,
   widths and FIFO depth, the control structs and the stream line types */
package rx_core_pkg;

   ////////////////////
   // Widths and depths
   localparam int SET_ADDR_W      = 8;
   localparam int SET_DATA_W      = 32;
   localparam int ADC_W           = 14;
   localparam int HALF_W          = 16;
   localparam int FIFO_DEPTH_LOG2 = 4;

   ////////////////////
   // Settings bus addresses
   localparam logic [SET_ADDR_W-1:0] SR_CLOCK      = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_SERDES     = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_ADC        = 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SW     = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_PHY        = 8'd4;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC    = 8'd8;
   localparam logic [SET_ADDR_W-1:0] SR_RX_CTRL    = 8'd176;
   localparam logic [SET_ADDR_W-1:0] SR_RX_LEN     = 8'd177;
   localparam logic [SET_ADDR_W-1:0] SR_RX_OVF_CLR = 8'd178;

   // Status LEDs under hardware control out of reset
   localparam logic [7:0] LED_SRC_AT_RESET = 8'b0001_1110;

   // One settings bus write
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // Board control levels
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
   } board_ctrl_t;

   typedef struct packed {
      logic              run;
      logic [HALF_W-1:0] len;
   } rx_ctrl_t;

   ////////////////////
   // Stream words
   typedef struct packed {
      logic [HALF_W-1:0] i;
      logic [HALF_W-1:0] q;
   } sample_t;

   typedef struct packed {
      logic [HALF_W-1:0] seq;
      logic [HALF_W-1:0] len;
   } header_t;

   typedef union packed {
      sample_t smp;
      header_t hdr;
   } rx_word_u;

   typedef struct packed {
      logic     sop;
      logic     eop;
      rx_word_u word;
   } rx_line_t;

endpackage

// File: design/settings_regs.sv
/* Settings bus decode into board control, LED and RX control registers,
   plus the per-bit LED source mux */
module settings_regs (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  rx_core_pkg::set_bus_t    set_i,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   input  logic                     rx_running_i,
   output rx_core_pkg::board_ctrl_t board_o,
   output logic                     phy_resetn_o,
   output logic [7:0]               leds_o,
   output rx_core_pkg::rx_ctrl_t    rx_ctrl_o,
   output logic                     ovf_clr_o
);

   rx_core_pkg::board_ctrl_t board_r;
   rx_core_pkg::rx_ctrl_t    rx_ctrl_r;
   logic                     phy_rst_r;
   logic [7:0]               led_sw_r;
   logic [7:0]               led_src_r;
   logic                     ovf_clr_r;
   logic [7:0]               led_hw;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         board_r   <= '0;
         rx_ctrl_r <= '0;
         phy_rst_r <= 1'b0;
         led_sw_r  <= '0;
         led_src_r <= rx_core_pkg::LED_SRC_AT_RESET;
         ovf_clr_r <= 1'b0;
      end else begin
         ovf_clr_r <= 1'b0;
         if (set_i.stb) begin
            case (set_i.addr)
               rx_core_pkg::SR_CLOCK:
                  {board_r.clock_ready, board_r.clk_en, board_r.clk_sel} <= set_i.data[4:0];
               rx_core_pkg::SR_SERDES:
                  {board_r.ser_enable, board_r.ser_prbsen,
                   board_r.ser_loopen, board_r.ser_rx_en} <= set_i.data[3:0];
               rx_core_pkg::SR_ADC:
                  {board_r.adc_oe_a, board_r.adc_on_a,
                   board_r.adc_oe_b, board_r.adc_on_b} <= set_i.data[3:0];
               rx_core_pkg::SR_LED_SW:     led_sw_r      <= set_i.data[7:0];
               rx_core_pkg::SR_PHY:        phy_rst_r     <= set_i.data[0];
               rx_core_pkg::SR_LED_SRC:    led_src_r     <= set_i.data[7:0];
               rx_core_pkg::SR_RX_CTRL:    rx_ctrl_r.run <= set_i.data[0];
               rx_core_pkg::SR_RX_LEN:     rx_ctrl_r.len <= set_i.data[15:0];
               // Strobe only, nothing stored
               rx_core_pkg::SR_RX_OVF_CLR: ovf_clr_r     <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   ////////////////////
   // LED mux
   // Hardware word, bit 4 down to bit 1 is running, clock, link, zero
   assign led_hw = {3'b000, rx_running_i, clk_status_i, serdes_link_up_i, 2'b00};

   // Source bit set selects hardware status
   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

   assign board_o      = board_r;
   assign phy_resetn_o = ~phy_rst_r;
   assign rx_ctrl_o    = rx_ctrl_r;
   assign ovf_clr_o    = ovf_clr_r;

endmodule

// File: design/rx_sample_packer.sv
/* ADC capture under run control, packet boundary marking and
   sticky overrun when the downstream FIFO is full */
module rx_sample_packer (
   input  logic                            dsp_clk,
   input  logic                            wb_rst,
   input  logic [rx_core_pkg::ADC_W-1:0]   adc_a_i,
   input  logic [rx_core_pkg::ADC_W-1:0]   adc_b_i,
   input  rx_core_pkg::rx_ctrl_t           rx_ctrl_i,
   input  logic                            ovf_clr_i,
   input  logic                            dst_rdy_i,
   output rx_core_pkg::rx_line_t           line_o,
   output logic                            src_rdy_o,
   output logic                            running_o,
   output logic                            overrun_o
);

   logic [rx_core_pkg::HALF_W-1:0] cnt;
   logic [rx_core_pkg::HALF_W:0]   cnt_next;
   logic                           due;
   logic                           hold;
   logic                           drop;
   logic                           last;
   logic                           valid_r;
   logic                           overrun_r;
   rx_core_pkg::rx_line_t          line_r;

   function automatic logic [rx_core_pkg::HALF_W-1:0] sign_ext(
      input logic [rx_core_pkg::ADC_W-1:0] v
   );
      logic signed [rx_core_pkg::HALF_W-1:0] w;
      // Left-justify, then shift back down with the sign bit copied
      w = $signed({v, {(rx_core_pkg::HALF_W-rx_core_pkg::ADC_W){1'b0}}});
      return w >>> (rx_core_pkg::HALF_W - rx_core_pkg::ADC_W);
   endfunction

   // Sample due every cycle in a packet, or when a new one may start
   assign due      = rx_ctrl_i.run | (cnt != '0);
   // Previous line still waiting on a full FIFO
   assign hold     = valid_r & ~dst_rdy_i;
   assign drop     = due & hold;
   assign cnt_next = {1'b0, cnt} + 1'b1;
   assign last     = cnt_next >= {1'b0, rx_ctrl_i.len};

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cnt       <= '0;
         valid_r   <= 1'b0;
         overrun_r <= 1'b0;
      end else begin
         if (due && !hold) begin
            valid_r <= 1'b1;
            cnt     <= last ? '0 : cnt_next[rx_core_pkg::HALF_W-1:0];
         end else if (dst_rdy_i) begin
            valid_r <= 1'b0;
         end
         if (ovf_clr_i)
            overrun_r <= 1'b0;
         // A new drop wins over a clear in the same cycle
         if (drop)
            overrun_r <= 1'b1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (due && !hold) begin
         line_r.sop        <= (cnt == '0);
         line_r.eop        <= last;
         line_r.word.smp.i <= sign_ext(adc_a_i);
         line_r.word.smp.q <= sign_ext(adc_b_i);
      end
   end

   assign line_o    = line_r;
   assign src_rdy_o = valid_r;
   assign running_o = due;
   assign overrun_o = overrun_r;

endmodule

// File: design/sample_fifo.sv
/* Sixteen-line circular buffer of stream lines with
   src_rdy/dst_rdy handshake on both sides */
module sample_fifo (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  rx_core_pkg::rx_line_t in_line_i,
   input  logic                  in_src_rdy_i,
   output logic                  in_dst_rdy_o,
   output rx_core_pkg::rx_line_t out_line_o,
   output logic                  out_src_rdy_o,
   input  logic                  out_dst_rdy_i
);

   rx_core_pkg::rx_line_t                     mem [1 << rx_core_pkg::FIFO_DEPTH_LOG2];
   logic [rx_core_pkg::FIFO_DEPTH_LOG2-1:0]   wr_ptr;
   logic [rx_core_pkg::FIFO_DEPTH_LOG2-1:0]   rd_ptr;
   logic [rx_core_pkg::FIFO_DEPTH_LOG2:0]     count;
   logic                                      wr_en;
   logic                                      rd_en;

   // Top count bit set only when all lines are used
   assign in_dst_rdy_o  = ~count[rx_core_pkg::FIFO_DEPTH_LOG2];
   assign out_src_rdy_o = (count != '0);
   assign wr_en         = in_src_rdy_i & in_dst_rdy_o;
   assign rd_en         = out_src_rdy_o & out_dst_rdy_i;
   assign out_line_o    = mem[rd_ptr];

   always_ff @(posedge dsp_clk) begin
      if (wr_en)
         mem[wr_ptr] <= in_line_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: design/rx_framer.sv
/* Packet framer that puts a sequence/length header line in front of
   each packet and forwards the sample lines behind it */
module rx_framer (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  rx_core_pkg::rx_line_t in_line_i,
   input  logic                  in_src_rdy_i,
   output logic                  in_dst_rdy_o,
   output rx_core_pkg::rx_line_t out_line_o,
   output logic                  out_src_rdy_o,
   input  logic                  out_dst_rdy_i,
   input  rx_core_pkg::rx_ctrl_t rx_ctrl_i
);

   typedef enum logic {
      ST_HDR,
      ST_BODY
   } state_t;

   state_t                         state;
   logic [rx_core_pkg::HALF_W-1:0] seq;
   rx_core_pkg::rx_line_t          hdr_line;
   rx_core_pkg::rx_line_t          body_line;
   logic                           out_fire;

   always_comb begin
      hdr_line              = '0;
      hdr_line.sop          = 1'b1;
      hdr_line.word.hdr.seq = seq;
      hdr_line.word.hdr.len = rx_ctrl_i.len;
      // Sop moves to the header
      body_line             = in_line_i;
      body_line.sop         = 1'b0;
   end

   ////////////////////
   // Output select
   always_comb begin
      if (state == ST_HDR) begin
         out_line_o    = hdr_line;
         out_src_rdy_o = in_src_rdy_i & in_line_i.sop;
         // Input held until the header is gone, stray lines are dropped
         in_dst_rdy_o  = ~in_line_i.sop;
      end else begin
         out_line_o    = body_line;
         out_src_rdy_o = in_src_rdy_i;
         in_dst_rdy_o  = out_dst_rdy_i;
      end
   end

   assign out_fire = out_src_rdy_o & out_dst_rdy_i;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state <= ST_HDR;
         seq   <= '0;
      end else begin
         case (state)
            ST_HDR: begin
               if (out_fire) begin
                  state <= ST_BODY;
                  seq   <= seq + 1'b1;
               end
            end
            ST_BODY: begin
               if (out_fire && in_line_i.eop)
                  state <= ST_HDR;
            end
            default: state <= ST_HDR;
         endcase
      end
   end

endmodule

// File: design/rx_core_top.sv
/* RX core top: settings registers, sample packer,
   sample FIFO and framer */
module rx_core_top (
   input  logic                            dsp_clk,
   input  logic                            wb_rst,
   input  rx_core_pkg::set_bus_t           set_i,
   input  logic [rx_core_pkg::ADC_W-1:0]   adc_a_i,
   input  logic [rx_core_pkg::ADC_W-1:0]   adc_b_i,
   input  logic                            clk_status_i,
   input  logic                            serdes_link_up_i,
   output rx_core_pkg::board_ctrl_t        board_o,
   output logic                            phy_resetn_o,
   output logic [7:0]                      leds_o,
   output logic                            overrun_o,
   output rx_core_pkg::rx_line_t           out_line_o,
   output logic                            out_src_rdy_o,
   input  logic                            out_dst_rdy_i
);

   rx_core_pkg::rx_ctrl_t rx_ctrl;
   logic                  ovf_clr;
   logic                  running;

   // Packer to FIFO
   rx_core_pkg::rx_line_t pk_line;
   logic                  pk_src_rdy;
   logic                  pk_dst_rdy;

   // FIFO to framer
   rx_core_pkg::rx_line_t ff_line;
   logic                  ff_src_rdy;
   logic                  ff_dst_rdy;

   settings_regs u_settings_regs (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .rx_running_i(running),
      .board_o(board_o), .phy_resetn_o(phy_resetn_o), .leds_o(leds_o),
      .rx_ctrl_o(rx_ctrl), .ovf_clr_o(ovf_clr)
   );

   rx_sample_packer u_packer (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .adc_a_i(adc_a_i), .adc_b_i(adc_b_i),
      .rx_ctrl_i(rx_ctrl), .ovf_clr_i(ovf_clr), .dst_rdy_i(pk_dst_rdy),
      .line_o(pk_line), .src_rdy_o(pk_src_rdy),
      .running_o(running), .overrun_o(overrun_o)
   );

   sample_fifo u_fifo (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .in_line_i(pk_line), .in_src_rdy_i(pk_src_rdy), .in_dst_rdy_o(pk_dst_rdy),
      .out_line_o(ff_line), .out_src_rdy_o(ff_src_rdy), .out_dst_rdy_i(ff_dst_rdy)
   );

   rx_framer u_framer (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .in_line_i(ff_line), .in_src_rdy_i(ff_src_rdy), .in_dst_rdy_o(ff_dst_rdy),
      .out_line_o(out_line_o), .out_src_rdy_o(out_src_rdy_o),
      .out_dst_rdy_i(out_dst_rdy_i), .rx_ctrl_i(rx_ctrl)
   );

endmodule

// File: include/rx_check_tasks.svh
/* Compare tasks for stream lines, board control, LEDs and flags,
   each stopping the run on the first mismatch */
`ifndef RX_CHECK_TASKS_SVH
`define RX_CHECK_TASKS_SVH

// Common failure report
task automatic report_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
   $display("ERR %s expected %h actual %h", name, exp, act);
   $display(">>> FAIL");
   $fatal(1, "mismatch on %s", name);
endtask

task automatic check_line(input string name, input rx_core_pkg::rx_line_t exp,
                          input rx_core_pkg::rx_line_t act);
   if (act !== exp)
      report_mismatch(name, 64'(exp), 64'(act));
endtask

task automatic check_board(input rx_core_pkg::board_ctrl_t exp,
                           input rx_core_pkg::board_ctrl_t act);
   if (act !== exp)
      report_mismatch("board_o", 64'(exp), 64'(act));
endtask

task automatic check_leds(input logic [7:0] exp, input logic [7:0] act);
   if (act !== exp)
      report_mismatch("leds_o", 64'(exp), 64'(act));
endtask

// Single-bit levels such as overrun and PHY reset
task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp)
      report_mismatch(name, 64'(exp), 64'(act));
endtask

`endif

// File: tests/rx_core_tb.sv
/* RX core testbench: clock, reset, test file reader, ADC ramp and stall
   stimulus, stream reference model and watchdog */
module rx_core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic                            dsp_clk;
   logic                            wb_rst;
   rx_core_pkg::set_bus_t           set_i;
   logic [rx_core_pkg::ADC_W-1:0]   adc_a_i;
   logic [rx_core_pkg::ADC_W-1:0]   adc_b_i;
   logic                            clk_status_i;
   logic                            serdes_link_up_i;
   rx_core_pkg::board_ctrl_t        board_o;
   logic                            phy_resetn_o;
   logic [7:0]                      leds_o;
   logic                            overrun_o;
   rx_core_pkg::rx_line_t           out_line_o;
   logic                            out_src_rdy_o;
   logic                            out_dst_rdy_i;

   // Reference model state
   logic [2*rx_core_pkg::ADC_W-1:0] ref_q [$];
   logic [rx_core_pkg::ADC_W-1:0]   ramp;
   logic [15:0]                     len_model;
   logic [15:0]                     exp_seq;
   logic [15:0]                     body_cnt;
   logic                            expect_hdr;
   logic                            ovf_seen;
   logic                            start_gap;
   logic                            quiet;
   int                              limit_cycles;
   string                           lines [$];

   `include "rx_check_tasks.svh"

   rx_core_top DUT (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #5 dsp_clk = ~dsp_clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "%s", msg);
   endtask

   function automatic logic [15:0] sext(input logic [13:0] v);
      return {{2{v[13]}}, v};
   endfunction

   ////////////////////
   // Stimulus
   task automatic drive_cycle(input logic rdy, input rx_core_pkg::set_bus_t s);
      @(negedge dsp_clk);
      set_i         = s;
      out_dst_rdy_i = rdy;
      ramp          = ramp + 1'b1;
      adc_a_i       = ramp;
      adc_b_i       = ~ramp;
      ref_q.push_back({ramp, ~ramp});
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      drive_cycle(1'b1, {1'b1, addr, data});
      if (addr == rx_core_pkg::SR_RX_LEN)
         len_model = data[15:0];
      // Pairs presented before a run starts are never captured
      if (addr == rx_core_pkg::SR_RX_CTRL && data[0])
         start_gap = 1'b1;
   endtask

   // Two idle cycles so a write is visible on the outputs
   task automatic settle();
      repeat (2) drive_cycle(1'b1, '0);
   endtask

   ////////////////////
   // Output stream model
   task automatic take_line(input rx_core_pkg::rx_line_t act);
      rx_core_pkg::rx_line_t           exp;
      logic [2*rx_core_pkg::ADC_W-1:0] pair;
      logic                            found;
      int                              skipped;
      exp     = '0;
      found   = 1'b0;
      skipped = 0;
      if (expect_hdr) begin
         exp.sop          = 1'b1;
         exp.word.hdr.seq = exp_seq;
         exp.word.hdr.len = len_model;
         check_line("out_line_o", exp, act);
         exp_seq    = exp_seq + 1'b1;
         expect_hdr = 1'b0;
         body_cnt   = '0;
      end else begin
         // Dropped samples leave gaps, so search forward
         while (!found && ref_q.size() > 0) begin
            pair             = ref_q.pop_front();
            exp.word.smp.i   = sext(pair[27:14]);
            exp.word.smp.q   = sext(pair[13:0]);
            if (exp.word === act.word)
               found = 1'b1;
            else
               skipped++;
         end
         if (!found)
            stop_with_error("Output sample is not in the ADC sequence");
         if (skipped != 0 && !start_gap && !ovf_seen)
            stop_with_error("ADC sample skipped without overrun");
         start_gap = 1'b0;
         body_cnt  = body_cnt + 1'b1;
         exp.eop   = (body_cnt == len_model);
         check_line("out_line_o", exp, act);
         if (exp.eop)
            expect_hdr = 1'b1;
      end
   endtask

   // Sample just before the rising edge, where all outputs are settled
   always @(negedge dsp_clk) begin
      #4;
      if (!wb_rst) begin
         if (overrun_o)
            ovf_seen = 1'b1;
         if (quiet && out_src_rdy_o)
            stop_with_error("Output line appeared after the run was stopped");
         if (out_src_rdy_o && out_dst_rdy_i)
            take_line(out_line_o);
      end
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge dsp_clk);
      $display("Timeout after %0d cycles, the tests did not finish", limit_cycles);
      $display(">>> FAIL");
      $fatal(1, "watchdog timeout");
   end

   ////////////////////
   // Test file sequencer
   initial begin
      int          fd;
      int          n;
      int          idle;
      int          budget;
      string       line;
      string       args;
      byte         cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      void'($urandom(32'hd667_51b0));
      wb_rst           = 1'b1;
      set_i            = '0;
      adc_a_i          = '0;
      adc_b_i          = '0;
      clk_status_i     = 1'b1;
      serdes_link_up_i = 1'b1;
      out_dst_rdy_i    = 1'b1;
      ramp             = 14'h1fc0;
      len_model        = '0;
      exp_seq          = '0;
      body_cnt         = '0;
      expect_hdr       = 1'b1;
      ovf_seen         = 1'b0;
      start_gap        = 1'b0;
      quiet            = 1'b0;
      limit_cycles     = 0;
      budget           = 100;

      fd = $fopen("tests/rx_tests.dat", "r");
      if (fd == 0)
         stop_with_error("Cannot open tests/rx_tests.dat");
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin
            lines.push_back(line);
            cmd = line[0];
            if (cmd == "r" || cmd == "s" || cmd == "z") begin
               void'($sscanf(line.substr(1, line.len() - 1), "%d", n));
               budget += n;
            end else if (cmd == "d") begin
               budget += 400;
            end else begin
               budget += 4;
            end
         end
      end
      $fclose(fd);
      limit_cycles = budget;

      repeat (5) @(posedge dsp_clk);
      @(negedge dsp_clk);
      wb_rst = 1'b0;

      foreach (lines[k]) begin
         line = lines[k];
         cmd  = line[0];
         args = line.substr(1, line.len() - 1);
         a    = '0;
         b    = '0;
         c    = '0;
         case (cmd)
            "w": begin
               void'($sscanf(args, "%h %h", a, b));
               write_setting(a[7:0], b);
            end
            "e": begin
               void'($sscanf(args, "%h %h %h", a, b, c));
               settle();
               check_board(rx_core_pkg::board_ctrl_t'(a[12:0]), board_o);
               check_leds(b[7:0], leds_o);
               check_flag("phy_resetn_o", c[0], phy_resetn_o);
            end
            "o": begin
               void'($sscanf(args, "%d", a));
               settle();
               check_flag("overrun_o", a[0], overrun_o);
            end
            "r": begin
               void'($sscanf(args, "%d", n));
               repeat (n) drive_cycle(1'b1, '0);
            end
            "s": begin
               void'($sscanf(args, "%d", n));
               repeat (n) drive_cycle(($urandom % 4) == 0, '0);
            end
            "z": begin
               void'($sscanf(args, "%d", n));
               quiet = 1'b1;
               repeat (n) drive_cycle(1'b1, '0);
               quiet = 1'b0;
            end
            "d": begin
               idle = 0;
               while (idle < 32) begin
                  drive_cycle(1'b1, '0);
                  idle = out_src_rdy_o ? 0 : idle + 1;
               end
               if (!expect_hdr)
                  stop_with_error("Drain ended inside a packet");
            end
            default: stop_with_error("Unknown command in the test file");
         endcase
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

// File: tests/rx_tests.dat
# Columns: command, then arguments
# w addr data (hex), e board leds phy_resetn (hex), o overrun, r/s/z cycles, d drain
# Reset values, no output
e 0000 0c 1
o 0
z 4
# Board control registers
w 00 00000015
w 01 0000000a
w 02 00000005
w 04 00000001
e 15a5 0c 0
# Unused addresses change nothing
w 05 ffffffff
w 07 ffffffff
w b3 ffffffff
e 15a5 0c 0
w 04 00000000
# LED software value and source select
w 03 000000a5
w 08 0000000f
e 15a5 ac 1
w 08 00000000
e 15a5 a5 1
w 08 0000001e
e 15a5 ad 1
# Framing with no stalls, length 8
w b1 00000008
w b0 00000001
r 53
o 0
# Stop mid-packet, nothing follows the last packet
w b0 00000000
d
z 40
# Random stalls fill the FIFO, length 5
w b1 00000005
w b0 00000001
s 150
o 1
w b0 00000000
d
# Overrun clear
w b2 00000000
o 0
z 30

// File: vlog.f
+incdir+include
design/rx_core_pkg.sv
design/settings_regs.sv
design/rx_sample_packer.sv
design/sample_fifo.sv
design/rx_framer.sv
design/rx_core_top.sv
tests/rx_core_tb.sv

// File: Makefile
# Verilator build and run of the RX core testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module rx_core_tb -f vlog.f \
		-Mdir obj_dir -o rx_core_sim

run: compile
	./obj_dir/rx_core_sim | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
